// ==== common/backend_cfg.svh ====
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// datapath widths
`define XLEN        64
`define PC_WIDTH    64
`define INSTR_WIDTH 32
`define LREG_WIDTH  5

// issue queue entries
`define IQ_DEPTH    4

`endif

// ==== common/backend_pkg.sv ====
`default_nettype none
`include "backend_cfg.svh"

package backend_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5      // signed compare
    } alu_op_e;

    typedef enum logic {
        LS_WORD   = 1'b0,
        LS_DOUBLE = 1'b1
    } ls_size_e;

    typedef struct packed {
        logic [`INSTR_WIDTH-1:0] instr;
        logic [`PC_WIDTH-1:0]    pc;
    } ibuf_entry_t;

    typedef struct packed {
        logic [`PC_WIDTH-1:0]   pc;
        logic [`LREG_WIDTH-1:0] lrs1;
        logic [`LREG_WIDTH-1:0] lrs2;
        logic [`LREG_WIDTH-1:0] lrd;
        logic [`XLEN-1:0]       imm;
        logic                   src2_is_imm;
        logic                   need_to_wb;
        alu_op_e                alu_op;         // also the address add for memory ops
        logic                   is_load;
        logic                   is_store;
        ls_size_e               ls_size;
        logic                   is_unsigned;
    } uop_t;

    typedef struct packed {
        logic [`PC_WIDTH-1:0]   pc;
        logic [`LREG_WIDTH-1:0] lrd;
        logic                   need_to_wb;
        logic [`XLEN-1:0]       result;
    } commit_t;

    typedef struct packed {
        logic [`XLEN-1:0] index;                // doubleword aligned byte address
        logic [`XLEN-1:0] write_data;
        logic [`XLEN-1:0] write_mask;           // bit mask
        logic             operation_type;       // 1 = store
    } tbus_req_t;

endpackage

`default_nettype wire

// ==== exu/exu_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module exu_top
    import backend_pkg::*;
(
    input  wire             clock,
    input  wire             rst,
    input  wire             uop_valid,
    output logic            uop_ready,
    input  wire uop_t       uop,

    output logic            tbus_index_valid,
    input  wire             tbus_index_ready,
    output tbus_req_t       tbus_req,
    input  wire [`XLEN-1:0] tbus_read_data,
    input  wire             tbus_operation_done,

    output logic            commit_valid,
    output commit_t         commit
);
    localparam int NUM_REGS = 1 << `LREG_WIDTH;

    logic [`XLEN-1:0] regs [NUM_REGS];
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] alu_src2;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] lsu_result;
    logic             is_mem;
    logic             accept;
    logic             mem_pending;      // access in flight until lsu_done
    logic             lsu_done;

    assign is_mem    = uop.is_load || uop.is_store;
    assign uop_ready = !mem_pending;
    assign accept    = uop_valid && uop_ready;
    assign src1      = (uop.lrs1 == '0) ? '0 : regs[uop.lrs1];     // x0 reads zero
    assign src2      = (uop.lrs2 == '0) ? '0 : regs[uop.lrs2];
    assign alu_src2  = uop.src2_is_imm ? uop.imm : src2;

    int_alu u_int_alu (
        .op    (uop.alu_op),
        .src1  (src1),
        .src2  (alu_src2),
        .result(alu_result)
    );

    lsu u_lsu (
        .clock              (clock),
        .rst                (rst),
        .start              (accept && is_mem),
        .addr               (alu_result),      // rs1 + imm
        .store_data         (src2),
        .ls_size            (uop.ls_size),
        .is_load            (uop.is_load),
        .is_unsigned        (uop.is_unsigned),
        .tbus_index_valid   (tbus_index_valid),
        .tbus_index_ready   (tbus_index_ready),
        .tbus_req           (tbus_req),
        .tbus_read_data     (tbus_read_data),
        .tbus_operation_done(tbus_operation_done),
        .done               (lsu_done),
        .load_result        (lsu_result)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            commit_valid <= 1'b0;
            mem_pending  <= 1'b0;
        end else begin
            commit_valid <= (accept && !is_mem) || lsu_done;
            if (accept && is_mem) begin
                mem_pending <= 1'b1;
            end else if (lsu_done) begin
                mem_pending <= 1'b0;
            end
        end
    end

    // record is built at accept, memory result lands on done
    always_ff @(posedge clock) begin
        if (accept) begin
            commit.pc         <= uop.pc;
            commit.lrd        <= uop.lrd;
            commit.need_to_wb <= uop.need_to_wb;
            if (!is_mem) commit.result <= alu_result;
        end
        if (lsu_done) commit.result <= lsu_result;
    end

    // write lands on the edge that raises commit_valid
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && !is_mem && uop.need_to_wb) begin
            regs[uop.lrd] <= alu_result;
        end else if (lsu_done && commit.need_to_wb) begin
            regs[commit.lrd] <= lsu_result;
        end
    end

endmodule

`default_nettype wire

// ==== exu/int_alu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module int_alu
    import backend_pkg::*;
(
    input  wire alu_op_e         op,
    input  wire [`XLEN-1:0]      src1,
    input  wire [`XLEN-1:0]      src2,
    output logic [`XLEN-1:0]     result
);
    logic lt_signed;

    assign lt_signed = ($signed(src1) < $signed(src2));

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = src1 + src2;
            end
            ALU_SUB: begin
                result = src1 - src2;       // wraps
            end
            ALU_AND: begin
                result = src1 & src2;
            end
            ALU_OR: begin
                result = src1 | src2;
            end
            ALU_XOR: begin
                result = src1 ^ src2;
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            default: begin
                result = src1 + src2;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== exu/lsu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module lsu
    import backend_pkg::*;
(
    input  wire              clock,
    input  wire              rst,
    input  wire              start,
    input  wire [`XLEN-1:0]  addr,
    input  wire [`XLEN-1:0]  store_data,
    input  wire ls_size_e    ls_size,
    input  wire              is_load,
    input  wire              is_unsigned,

    output logic             tbus_index_valid,
    input  wire              tbus_index_ready,
    output tbus_req_t        tbus_req,
    input  wire [`XLEN-1:0]  tbus_read_data,
    input  wire              tbus_operation_done,

    output logic             done,
    output logic [`XLEN-1:0] load_result
);
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_WAIT
    } lsu_state_e;

    lsu_state_e       state;
    logic [`XLEN-1:0] addr_q;
    logic [`XLEN-1:0] data_q;
    ls_size_e         size_q;
    logic             load_q;
    logic             unsigned_q;
    logic [`XLEN-1:0] lane_data;
    logic [`XLEN-1:0] lane_mask;
    logic [31:0]      load_word;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= LSU_IDLE;
        end else begin
            case (state)
                LSU_IDLE: if (start) state <= LSU_REQ;
                LSU_REQ:  if (tbus_index_ready) state <= LSU_WAIT;
                LSU_WAIT: if (tbus_operation_done) state <= LSU_IDLE;
                default:  state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start && state == LSU_IDLE) begin
            addr_q     <= addr;
            data_q     <= store_data;
            size_q     <= ls_size;
            load_q     <= is_load;
            unsigned_q <= is_unsigned;
        end
    end

    // word stores go to the half picked by addr[2]
    always_comb begin
        if (size_q == LS_DOUBLE) begin
            lane_data = data_q;
            lane_mask = '1;
        end else if (addr_q[2]) begin
            lane_data = {data_q[31:0], 32'b0};
            lane_mask = {{32{1'b1}}, 32'b0};
        end else begin
            lane_data = {32'b0, data_q[31:0]};
            lane_mask = {32'b0, {32{1'b1}}};
        end
    end

    always_comb begin
        tbus_req.index          = {addr_q[`XLEN-1:3], 3'b000};
        tbus_req.write_data     = load_q ? '0 : lane_data;
        tbus_req.write_mask     = load_q ? '0 : lane_mask;
        tbus_req.operation_type = !load_q;
    end

    assign tbus_index_valid = (state == LSU_REQ);
    assign done             = (state == LSU_WAIT) && tbus_operation_done;
    assign load_word        = addr_q[2] ? tbus_read_data[63:32] : tbus_read_data[31:0];

    always_comb begin
        if (!load_q) begin
            load_result = addr_q;       // stores report their address
        end else if (size_q == LS_DOUBLE) begin
            load_result = tbus_read_data;
        end else if (unsigned_q) begin
            load_result = {32'b0, load_word};
        end else begin
            load_result = {{32{load_word[31]}}, load_word};
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -f src.f --top-module tb_backend -o tb_backend_sim &&
./obj_dir/tb_backend_sim | tee sim.log
grep -qx "sim passed" sim.log && echo "simulation ok" || { echo "simulation did not pass"; exit 1; }

// ==== source/backend.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module backend
    import backend_pkg::*;
(
    input  wire              clock,
    input  wire              rst,

    input  wire              ibuffer_instr_valid,
    output logic             ibuffer_instr_ready,
    input  wire ibuf_entry_t ibuffer_entry,

    output logic             tbus_index_valid,
    input  wire              tbus_index_ready,
    output tbus_req_t        tbus_req,
    input  wire [`XLEN-1:0]  tbus_read_data,
    input  wire              tbus_operation_done,

    output logic             commit_valid,
    output commit_t          commit
);
    logic dec_valid;
    logic dec_ready;
    uop_t dec_uop;
    logic iq_valid;
    logic iq_ready;
    uop_t iq_uop;

    instr_decoder u_instr_decoder (
        .clock    (clock),
        .rst      (rst),
        .in_valid (ibuffer_instr_valid),
        .in_ready (ibuffer_instr_ready),
        .in_entry (ibuffer_entry),
        .out_valid(dec_valid),
        .out_ready(dec_ready),
        .out_uop  (dec_uop)
    );

    issue_queue u_issue_queue (
        .clock    (clock),
        .rst      (rst),
        .in_valid (dec_valid),
        .in_ready (dec_ready),
        .in_uop   (dec_uop),
        .out_valid(iq_valid),
        .out_ready(iq_ready),
        .out_uop  (iq_uop)
    );

    exu_top u_exu_top (
        .clock              (clock),
        .rst                (rst),
        .uop_valid          (iq_valid),
        .uop_ready          (iq_ready),
        .uop                (iq_uop),
        .tbus_index_valid   (tbus_index_valid),
        .tbus_index_ready   (tbus_index_ready),
        .tbus_req           (tbus_req),
        .tbus_read_data     (tbus_read_data),
        .tbus_operation_done(tbus_operation_done),
        .commit_valid       (commit_valid),
        .commit             (commit)
    );

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module instr_decoder
    import backend_pkg::*;
(
    input  wire              clock,
    input  wire              rst,
    input  wire              in_valid,
    output logic             in_ready,
    input  wire ibuf_entry_t in_entry,
    output logic             out_valid,
    input  wire              out_ready,
    output uop_t             out_uop
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    logic [`INSTR_WIDTH-1:0] instr;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`XLEN-1:0]        imm_i;
    logic [`XLEN-1:0]        imm_s;
    logic                    legal;
    uop_t                    dec_uop;

    assign instr  = in_entry.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s  = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        legal          = 1'b0;
        dec_uop        = '0;
        dec_uop.pc     = in_entry.pc;
        dec_uop.lrs1   = instr[19:15];
        dec_uop.lrs2   = instr[24:20];
        dec_uop.lrd    = instr[11:7];
        dec_uop.imm    = imm_i;
        dec_uop.alu_op = ALU_ADD;       // unknown encodings fall through as add
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    legal = 1'b1;
                    case (funct3)
                        3'b000:  dec_uop.alu_op = ALU_ADD;
                        3'b010:  dec_uop.alu_op = ALU_SLT;
                        3'b100:  dec_uop.alu_op = ALU_XOR;
                        3'b110:  dec_uop.alu_op = ALU_OR;
                        3'b111:  dec_uop.alu_op = ALU_AND;
                        default: legal = 1'b0;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    legal          = 1'b1;
                    dec_uop.alu_op = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                dec_uop.src2_is_imm = 1'b1;
                legal               = 1'b1;
                case (funct3)
                    3'b000:  dec_uop.alu_op = ALU_ADD;
                    3'b100:  dec_uop.alu_op = ALU_XOR;
                    3'b110:  dec_uop.alu_op = ALU_OR;
                    3'b111:  dec_uop.alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                dec_uop.src2_is_imm = 1'b1;
                if (funct3 == 3'b010 || funct3 == 3'b110 || funct3 == 3'b011) begin
                    legal               = 1'b1;
                    dec_uop.is_load     = 1'b1;
                    dec_uop.is_unsigned = funct3[2];    // lwu
                    dec_uop.ls_size     = funct3[0] ? LS_DOUBLE : LS_WORD;
                end
            end
            OPC_STORE: begin
                dec_uop.src2_is_imm = 1'b1;
                dec_uop.imm         = imm_s;
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    legal            = 1'b1;
                    dec_uop.is_store = 1'b1;
                    dec_uop.ls_size  = funct3[0] ? LS_DOUBLE : LS_WORD;
                end
            end
            default: legal = 1'b0;
        endcase
        dec_uop.need_to_wb = legal && !dec_uop.is_store && (dec_uop.lrd != '0);
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_uop <= dec_uop;
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_queue.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module issue_queue
    import backend_pkg::*;
(
    input  wire       clock,
    input  wire       rst,
    input  wire       in_valid,
    output logic      in_ready,
    input  wire uop_t in_uop,
    output logic      out_valid,
    input  wire       out_ready,
    output uop_t      out_uop
);
    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    uop_t             entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != FULL_COUNT);
    assign out_valid = (count != '0);
    assign out_uop   = entries[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= in_uop;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/backend_pkg.sv
source/instr_decoder.sv
source/issue_queue.sv
exu/int_alu.sv
exu/lsu.sv
exu/exu_top.sv
source/backend.sv
verif/tb_backend.sv

// ==== verif/tb_backend.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "backend_cfg.svh"

module tb_backend
    import backend_pkg::*;
();
    localparam int NUM_INSTR    = 400;
    localparam int STEP_TIMEOUT = 2000;
    localparam int RUN_TIMEOUT  = 40000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // funct3 per kind in kind_names order
    localparam logic [2:0] KIND_F3 [15] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
        3'b010, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b110, 3'b011, 3'b010, 3'b011};

    logic             clock;
    logic             rst;
    logic             ibuffer_instr_valid;
    logic             ibuffer_instr_ready;
    ibuf_entry_t      ibuffer_entry;
    logic             tbus_index_valid;
    logic             tbus_index_ready;
    tbus_req_t        tbus_req;
    logic [`XLEN-1:0] tbus_read_data;
    logic             tbus_operation_done;
    logic             commit_valid;
    commit_t          commit;

    logic [31:0]      lfsr_state;
    ibuf_entry_t      program_q [NUM_INSTR];
    commit_t          exp_commits [$];
    string            exp_names [$];
    tbus_req_t        exp_stores [$];
    logic [63:0]      model_regs [32];
    logic [63:0]      model_mem [16];
    logic [63:0]      bus_mem [16];      // memory seen by the responder
    int               commits_seen;
    int               stores_seen;
    logic             run_finished;
    logic             saw_backpressure;
    string            kind_names [15] = '{"add", "sub", "and", "or", "xor", "slt", "addi",
        "andi", "ori", "xori", "lw", "lwu", "ld", "sw", "sd"};

    backend i_dut (
        .clock              (clock),
        .rst                (rst),
        .ibuffer_instr_valid(ibuffer_instr_valid),
        .ibuffer_instr_ready(ibuffer_instr_ready),
        .ibuffer_entry      (ibuffer_entry),
        .tbus_index_valid   (tbus_index_valid),
        .tbus_index_ready   (tbus_index_ready),
        .tbus_req           (tbus_req),
        .tbus_read_data     (tbus_read_data),
        .tbus_operation_done(tbus_operation_done),
        .commit_valid       (commit_valid),
        .commit             (commit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};    // one step per bit
        end
        return bits;
    endfunction

    function automatic logic [63:0] alu_model(input int op, input logic [63:0] a,
                                              input logic [63:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        endcase
    endfunction

    function automatic string commit_text(input commit_t c);
        return $sformatf("pc=%h lrd=%0d wb=%b result=%h", c.pc, c.lrd, c.need_to_wb,
                         c.result);
    endfunction

    function automatic string tbus_req_text(input tbus_req_t r);
        return $sformatf("index=%h data=%h mask=%h type=%b", r.index, r.write_data,
                         r.write_mask, r.operation_type);
    endfunction

    task automatic halt_on_error();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("error: %s", what);
        halt_on_error();
    endtask

    task automatic compare_commit(input string test_name, input commit_t expected,
                                  input commit_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %s actual %s", test_name, commit_text(expected),
                     commit_text(actual));
            halt_on_error();
        end
    endtask

    task automatic compare_tbus_req(input string test_name, input tbus_req_t expected,
                                    input tbus_req_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %s actual %s", test_name, tbus_req_text(expected),
                     tbus_req_text(actual));
            halt_on_error();
        end
    endtask

    // random program and its expected commits
    task automatic build_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] instr;
        logic [31:0] word;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] addr;
        logic [63:0] res;
        logic [63:0] lane_data;
        logic [63:0] lane_mask;
        commit_t     exp;
        tbus_req_t   req;
        for (int i = 0; i < NUM_INSTR; i++) begin
            kind = int'(take_bits(4) % 15);
            rd   = 5'(take_bits(3));
            rs1  = 5'(take_bits(3));
            rs2  = 5'(take_bits(3));
            imm  = 12'(take_bits(12));
            a    = model_regs[rs1];
            b    = model_regs[rs2];
            if (kind < 6) begin
                instr = {(kind == 1) ? 7'h20 : 7'h00, rs2, rs1, KIND_F3[kind], rd, 7'b0110011};
                res   = alu_model(kind, a, b);
            end else if (kind < 10) begin
                instr = {imm, rs1, KIND_F3[kind], rd, 7'b0010011};
                res   = alu_model((kind == 6) ? 0 : kind - 5, a, {{52{imm[11]}}, imm});
            end else if (kind < 13) begin
                addr  = (kind == 12) ? (take_bits(4) << 3) : (take_bits(5) << 2);
                instr = {addr[11:0], 5'd0, KIND_F3[kind], rd, 7'b0000011};
                word  = addr[2] ? model_mem[addr[6:3]][63:32] : model_mem[addr[6:3]][31:0];
                if (kind == 12) begin
                    res = model_mem[addr[6:3]];
                end else if (kind == 11) begin
                    res = {32'b0, word};
                end else begin
                    res = {{32{word[31]}}, word};
                end
            end else begin
                addr  = (kind == 14) ? (take_bits(4) << 3) : (take_bits(5) << 2);
                instr = {addr[11:5], rs2, 5'd0, KIND_F3[kind], addr[4:0], 7'b0100011};
                if (kind == 14) begin
                    lane_data = b;
                    lane_mask = '1;
                end else if (addr[2]) begin
                    lane_data = {b[31:0], 32'b0};
                    lane_mask = {{32{1'b1}}, 32'b0};
                end else begin
                    lane_data = {32'b0, b[31:0]};
                    lane_mask = {32'b0, {32{1'b1}}};
                end
                req.index          = {addr[63:3], 3'b000};
                req.write_data     = lane_data;
                req.write_mask     = lane_mask;
                req.operation_type = 1'b1;
                exp_stores.push_back(req);
                model_mem[addr[6:3]] = (model_mem[addr[6:3]] & ~lane_mask) |
                                       (lane_data & lane_mask);
                res = addr;     // stores report their address
            end
            exp.pc         = 64'h1000 + 64'(4 * i);
            exp.lrd        = instr[11:7];
            exp.need_to_wb = (kind < 13) && (rd != 5'd0);
            exp.result     = res;
            if (exp.need_to_wb) model_regs[rd] = res;
            program_q[i].instr = instr;
            program_q[i].pc    = exp.pc;
            exp_commits.push_back(exp);
            exp_names.push_back(kind_names[kind]);
        end
    endtask

    task automatic feed_program();
        int wait_count;
        for (int i = 0; i < NUM_INSTR; i++) begin
            ibuffer_instr_valid <= 1'b1;
            ibuffer_entry       <= program_q[i];
            wait_count = 0;
            do begin
                @(posedge clock);
                wait_count++;
                if (!ibuffer_instr_ready) saw_backpressure = 1'b1;
                if (wait_count > STEP_TIMEOUT) begin
                    report_problem($sformatf("instruction %0d was never accepted", i));
                end
            end while (!ibuffer_instr_ready);
        end
        ibuffer_instr_valid <= 1'b0;
    endtask

    task automatic check_commits();
        int cycles;
        cycles = 0;
        while (commits_seen < NUM_INSTR) begin
            @(posedge clock);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                report_problem($sformatf("timed out after %0d of %0d commits",
                                         commits_seen, NUM_INSTR));
            end
            if (commit_valid) begin
                compare_commit($sformatf("commit %0d (%s)", commits_seen, exp_names.pop_front()),
                               exp_commits.pop_front(), commit);
                commits_seen++;
            end
        end
        repeat (20) begin
            @(posedge clock);
            if (commit_valid) report_problem("extra commit after the last instruction");
        end
        run_finished = 1'b1;
    endtask

    // memory responder with random ready and done delays
    task automatic serve_tbus();
        int         delay;
        int         idle;
        tbus_req_t  req;
        logic [3:0] slot;
        idle = 0;
        while (!run_finished) begin
            @(posedge clock);
            if (tbus_index_valid) begin
                idle  = 0;
                delay = int'(take_bits(3) % 7);
                repeat (delay) @(posedge clock);
                tbus_index_ready <= 1'b1;
                @(posedge clock);
                if (!tbus_index_valid) report_problem("TBUS request withdrawn before ready");
                req  = tbus_req;
                slot = req.index[6:3];
                tbus_index_ready <= 1'b0;
                if (req.operation_type) begin
                    if (exp_stores.size() == 0) report_problem("unexpected TBUS store request");
                    compare_tbus_req($sformatf("store request %0d", stores_seen),
                                     exp_stores.pop_front(), req);
                    stores_seen++;
                    bus_mem[slot] = (bus_mem[slot] & ~req.write_mask) |
                                    (req.write_data & req.write_mask);
                end
                delay = int'(take_bits(3) % 7);
                repeat (delay) @(posedge clock);
                tbus_operation_done <= 1'b1;
                tbus_read_data      <= bus_mem[slot];
                @(posedge clock);
                tbus_operation_done <= 1'b0;
            end else begin
                idle++;
                if (idle > STEP_TIMEOUT) report_problem("no TBUS request for too long");
            end
        end
    endtask

    initial begin
        rst                 <= 1'b1;
        ibuffer_instr_valid <= 1'b0;
        ibuffer_entry       <= '0;
        tbus_index_ready    <= 1'b0;
        tbus_read_data      <= '0;
        tbus_operation_done <= 1'b0;
        lfsr_state       = 32'd85311;
        run_finished     = 1'b0;
        saw_backpressure = 1'b0;
        commits_seen     = 0;
        stores_seen      = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = take_bits(64);
            bus_mem[i]   = model_mem[i];
        end
        build_program();
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        fork
            feed_program();
            check_commits();
            serve_tbus();
        join
        if (exp_stores.size() != 0) begin
            report_problem("some expected store requests never reached the TBUS");
        end else if (!saw_backpressure) begin
            report_problem("ibuffer_instr_ready never dropped under TBUS delays");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
